/* i2c_bit_engine.sv */
module i2c_bit_engine #(
  parameter int clk_mhz = 25,
  parameter int scl_khz = 100
) (
  input  logic              clk,
  input  logic              arst_n,
  input  i2c_pkg::bit_cmd_t cmd,
  input  logic              cmd_valid,
  output logic              cmd_done,
  output logic              rx_bit,
  output logic              ready,
  output logic              scl_oe,
  output logic              sda_oe,
  input  logic              scl_i,
  input  logic              sda_i
);
  import i2c_pkg::*;

  // clocks per quarter of an scl period
  localparam int quarter_clks = clk_mhz * 1000 / (4 * scl_khz);
  localparam int qw           = $clog2(quarter_clks + 1);
  localparam int iw           = $clog2(init_quarters + 1);

  logic [qw-1:0] qcnt;
  logic          tick;
  logic [iw-1:0] init_cnt;
  logic          active;
  logic [1:0]    phase;
  bit_cmd_t      cmd_q;
  logic          scl_drv;
  logic          sda_drv;

  assign tick = (qcnt == qw'(quarter_clks - 1));

  // quarter counter
  // restarts with each command so all four quarters are full length
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      qcnt <= '0;
    end else if (cmd_valid || tick || (ready && !active)) begin
      qcnt <= '0;
    end else begin
      qcnt <= qcnt + qw'(1);
    end
  end

  // command register
  always_ff @(posedge clk) begin
    if (ready && cmd_valid && !active) begin
      cmd_q <= cmd;
    end
  end

  // line pattern per command and quarter
  always_comb begin
    case (cmd_q.op)
      op_start: begin
        // sda falls in quarter 1 while scl is high
        scl_drv = (phase == 2'd3);
        sda_drv = (phase != 2'd0);
      end
      op_restart: begin
        // release sda, raise scl, then start
        scl_drv = (phase == 2'd0) || (phase == 2'd3);
        sda_drv = (phase >= 2'd2);
      end
      op_stop: begin
        // sda rises in quarter 2 while scl is high
        scl_drv = (phase == 2'd0);
        sda_drv = (phase <= 2'd1);
      end
      default: begin
        // data bit held through the whole scl pulse
        scl_drv = (phase == 2'd0) || (phase == 2'd3);
        sda_drv = (cmd_q.op == op_write) && !cmd_q.data;
      end
    endcase
  end

  // init wait then command sequencing
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      init_cnt <= '0;
      ready    <= 1'b0;
      active   <= 1'b0;
      phase    <= 2'd0;
      cmd_done <= 1'b0;
      rx_bit   <= 1'b0;
      scl_oe   <= 1'b0;
      sda_oe   <= 1'b0;
    end else begin
      cmd_done <= 1'b0;
      if (!ready) begin
        if (tick) begin
          // bus counts as free only with both lines high
          if (!(sda_i && scl_i)) begin
            init_cnt <= '0;
          end else if (init_cnt == iw'(init_quarters - 1)) begin
            ready <= 1'b1;
          end else begin
            init_cnt <= init_cnt + iw'(1);
          end
        end
      end else if (cmd_valid && !active) begin
        active <= 1'b1;
        phase  <= 2'd0;
      end else if (active && tick) begin
        // end of quarter 1 is the middle of scl high
        if (phase == 2'd1) begin
          rx_bit <= sda_i;
        end
        if (phase == 2'd3) begin
          active   <= 1'b0;
          cmd_done <= 1'b1;
        end
        phase <= phase + 2'd1;
      end
      // pins keep the last quarter's levels between commands
      if (active) begin
        scl_oe <= scl_drv;
        sda_oe <= sda_drv;
      end
    end
  end

endmodule

/* i2c_cpu_regs.sv */
module i2c_cpu_regs (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic [1:0]              addr,
  input  logic [7:0]              wdata,
  output logic [7:0]              rdata,
  input  logic                    csn,
  input  logic                    wrn,
  input  logic                    rdn,
  output logic                    start,
  output i2c_pkg::ctrl_word_u     ctrl,
  input  i2c_pkg::status_fields_t seq_status
);
  import i2c_pkg::*;

  logic         wr_en;
  logic         rd_en;
  logic         go_wr;
  logic         go_ok;
  logic         overrun;
  status_word_u rb;

  // active low strobes from the cpu
  assign wr_en = !csn && !wrn;
  assign rd_en = !csn && !rdn;

  // byte 0 write is the go request
  assign go_wr = wr_en && (addr == go_byte);
  // a start pulse not yet seen by the sequencer also counts as busy
  assign go_ok = go_wr && !seq_status.busy && !start;

  // control bytes
  // bytes 1 to 3 may be rewritten during a running transaction
  always_ff @(posedge clk) begin
    if (wr_en && ((addr != go_byte) || go_ok)) begin
      ctrl.bytes[addr] <= wdata;
    end
  end

  // start strobe and overrun flag
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      start   <= 1'b0;
      overrun <= 1'b0;
    end else begin
      start <= go_ok;
      if (go_ok) begin
        overrun <= 1'b0;
      end else if (go_wr) begin
        // go while busy is dropped
        overrun <= 1'b1;
      end
    end
  end

  // status as the cpu sees it
  always_comb begin
    rb.f         = seq_status;
    rb.f.busy    = seq_status.busy || start;
    rb.f.overrun = overrun;
  end

  // registered read-back of the addressed byte
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata <= rb.bytes[addr];
    end
  end

endmodule

/* i2c_master_8bit.sv */
module i2c_master_8bit #(
  parameter int clk_mhz = 25,
  parameter int scl_khz = 100
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic [1:0] addr,
  input  logic [7:0] wdata,
  output logic [7:0] rdata,
  input  logic       csn,
  input  logic       wrn,
  input  logic       rdn,
  output logic       scl_oe,
  output logic       sda_oe,
  input  logic       scl_i,
  input  logic       sda_i
);
  import i2c_pkg::*;

  logic           start;
  ctrl_word_u     ctrl;
  status_fields_t seq_status;
  bit_cmd_t       cmd;
  logic           cmd_valid;
  logic           cmd_done;
  logic           rx_bit;
  logic           ready;

  // cpu side register file
  i2c_cpu_regs i_cpu_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .addr       (addr),
    .wdata      (wdata),
    .rdata      (rdata),
    .csn        (csn),
    .wrn        (wrn),
    .rdn        (rdn),
    .start      (start),
    .ctrl       (ctrl),
    .seq_status (seq_status)
  );

  // frame level control
  i2c_sequencer i_sequencer (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .ctrl      (ctrl),
    .ready     (ready),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_done  (cmd_done),
    .rx_bit    (rx_bit),
    .status    (seq_status)
  );

  // scl timing and open drain pins
  i2c_bit_engine #(
    .clk_mhz (clk_mhz),
    .scl_khz (scl_khz)
  ) i_bit_engine (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_done  (cmd_done),
    .rx_bit    (rx_bit),
    .ready     (ready),
    .scl_oe    (scl_oe),
    .sda_oe    (sda_oe),
    .scl_i     (scl_i),
    .sda_i     (sda_i)
  );

endmodule

/* i2c_pkg.sv */
package i2c_pkg;

  // bus free time after reset, in quarter periods
  localparam int init_quarters = 8;

  // byte address whose write launches a transaction
  localparam logic [1:0] go_byte = 2'd0;

  // r/w bit appended to the slave address
  localparam logic rw_write = 1'b0;
  localparam logic rw_read  = 1'b1;

  // acknowledge levels on sda
  localparam logic ack_bit  = 1'b0;
  localparam logic nack_bit = 1'b1;

  // control word as consumed by the sequencer
  typedef struct packed {
    logic       read;
    logic       restart;
    logic [6:0] rsvd;
    logic [6:0] slave_addr;
    logic [7:0] subaddr;
    logic [7:0] wr_data;
  } ctrl_fields_t;

  // written bytewise by the cpu, read fieldwise by the sequencer
  typedef union packed {
    logic [3:0][7:0] bytes;
    ctrl_fields_t    f;
  } ctrl_word_u;

  // status flags in the top byte, read data in the bottom one
  typedef struct packed {
    logic        busy;
    logic        addr_nack;
    logic        data_nack;
    logic        rd_done;
    logic        overrun;
    logic        init;
    logic [17:0] zero;
    logic [7:0]  rd_data;
  } status_fields_t;

  typedef union packed {
    logic [3:0][7:0] bytes;
    status_fields_t  f;
  } status_word_u;

  // one bus command for the bit engine
  typedef enum logic [2:0] {
    op_start,
    op_restart,
    op_stop,
    op_write,
    op_read
  } bit_op_e;

  typedef struct packed {
    bit_op_e op;
    logic    data;
  } bit_cmd_t;

endpackage

/* i2c_sequencer.sv */
module i2c_sequencer (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    start,
  input  i2c_pkg::ctrl_word_u     ctrl,
  input  logic                    ready,
  output i2c_pkg::bit_cmd_t       cmd,
  output logic                    cmd_valid,
  input  logic                    cmd_done,
  input  logic                    rx_bit,
  output i2c_pkg::status_fields_t status
);
  import i2c_pkg::*;

  typedef enum logic [2:0] {
    st_idle, st_start, st_tx, st_ack, st_mid, st_rx, st_nack, st_stop
  } state_e;

  // which byte of the frame is on the bus
  typedef enum logic [1:0] {
    ph_addr_w, ph_sub, ph_data, ph_addr_r
  } phase_e;

  state_e       state;
  phase_e       phase;
  logic [2:0]   bit_cnt;
  logic         pending;
  logic         addr_nack;
  logic         data_nack;
  logic         rd_done;
  logic [7:0]   rd_data;
  logic [7:0]   rx_sh;
  logic [7:0]   tx_byte;
  ctrl_fields_t req;
  bit_cmd_t     next_cmd;

  // byte to shift out in the current phase
  always_comb begin
    case (phase)
      ph_addr_w: tx_byte = {req.slave_addr, rw_write};
      ph_sub:    tx_byte = req.subaddr;
      ph_data:   tx_byte = req.wr_data;
      default:   tx_byte = {req.slave_addr, rw_read};
    endcase
  end

  // command belonging to each state
  always_comb begin
    next_cmd.op   = op_stop;
    next_cmd.data = nack_bit;
    case (state)
      st_start: next_cmd.op = op_start;
      st_tx: begin
        // msb first
        next_cmd.op   = op_write;
        next_cmd.data = tx_byte[bit_cnt];
      end
      st_ack, st_rx: next_cmd.op = op_read;
      // repeated start or stop then fresh start
      st_mid: next_cmd.op = req.restart ? op_restart : op_stop;
      // master nack ends the read
      st_nack: next_cmd.op = op_write;
      default: next_cmd.op = op_stop;
    endcase
  end

  // request fields and read shifter
  always_ff @(posedge clk) begin
    if ((state == st_idle) && start) begin
      req <= ctrl.f;
    end
    if ((state == st_rx) && pending && cmd_done) begin
      rx_sh <= {rx_sh[6:0], rx_bit};
    end
  end

  // main FSM
  // one command out, wait for its done, then step
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= st_idle;
      phase     <= ph_addr_w;
      bit_cnt   <= 3'd0;
      pending   <= 1'b0;
      cmd_valid <= 1'b0;
      cmd       <= '0;
      addr_nack <= 1'b0;
      data_nack <= 1'b0;
      rd_done   <= 1'b0;
      rd_data   <= 8'd0;
    end else begin
      cmd_valid <= 1'b0;
      if (state == st_idle) begin
        if (start && ready) begin
          state     <= st_start;
          phase     <= ph_addr_w;
          addr_nack <= 1'b0;
          data_nack <= 1'b0;
          rd_done   <= 1'b0;
        end
      end else if (!pending) begin
        cmd       <= next_cmd;
        cmd_valid <= 1'b1;
        pending   <= 1'b1;
      end else if (cmd_done) begin
        pending <= 1'b0;
        case (state)
          st_start: begin
            state   <= st_tx;
            bit_cnt <= 3'd7;
          end
          st_tx: begin
            if (bit_cnt == 3'd0) begin
              state <= st_ack;
            end else begin
              bit_cnt <= bit_cnt - 3'd1;
            end
          end
          st_ack: begin
            bit_cnt <= 3'd7;
            if (rx_bit != ack_bit) begin
              // no ack ends the frame
              state <= st_stop;
              if ((phase == ph_addr_w) || (phase == ph_addr_r)) begin
                addr_nack <= 1'b1;
              end else begin
                data_nack <= 1'b1;
              end
            end else begin
              case (phase)
                ph_addr_w: begin
                  phase <= ph_sub;
                  state <= st_tx;
                end
                ph_sub: begin
                  if (req.read) begin
                    phase <= ph_addr_r;
                    state <= st_mid;
                  end else begin
                    phase <= ph_data;
                    state <= st_tx;
                  end
                end
                ph_data: state <= st_stop;
                default: state <= st_rx;
              endcase
            end
          end
          // restart already holds a start condition
          st_mid: state <= req.restart ? st_tx : st_start;
          st_rx: begin
            if (bit_cnt == 3'd0) begin
              rd_data <= {rx_sh[6:0], rx_bit};
              state   <= st_nack;
            end else begin
              bit_cnt <= bit_cnt - 3'd1;
            end
          end
          st_nack: begin
            rd_done <= 1'b1;
            state   <= st_stop;
          end
          // done of the stop ends busy
          default: state <= st_idle;
        endcase
      end
    end
  end

  // status toward the register front end
  always_comb begin
    status           = '0;
    status.busy      = (state != st_idle) || !ready;
    status.addr_nack = addr_nack;
    status.data_nack = data_nack;
    status.rd_done   = rd_done;
    status.init      = !ready;
    status.rd_data   = rd_data;
  end

endmodule

/* run.sh */
#!/bin/sh
# build and run, pass only if the testbench reports success
verilator --binary --timing -f tb.f --top-module tb_i2c_master_8bit -o sim_tb &&
  ./obj_dir/sim_tb 2>&1 | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

/* tb.f */
i2c_pkg.sv
i2c_cpu_regs.sv
i2c_sequencer.sv
i2c_bit_engine.sv
i2c_master_8bit.sv
tb_i2c_slave.sv
tb_i2c_master_8bit.sv

/* tb_i2c_master_8bit.sv */
module tb_i2c_master_8bit;

  localparam logic [6:0] dev_addr = 7'h6f;
  localparam int n_writes = 40;
  localparam int n_reads  = 40;
  // write and read loops plus address nack, data nack and two overrun frames
  localparam int n_trans     = n_writes + n_reads + 4;
  localparam longint wd_time = longint'(n_trans) * 40 * 16 * 40 * 2;

  logic       clk;
  logic       arst_n;
  logic [1:0] addr;
  logic [7:0] wdata;
  logic [7:0] rdata;
  logic       csn;
  logic       wrn;
  logic       rdn;
  logic       scl_oe;
  logic       sda_oe;
  logic       slave_sda_low;
  wire        scl;
  wire        sda;

  logic [31:0] lfsr;
  logic [7:0]  mirror [256];

  // wired-and of the open drain lines
  assign scl = !scl_oe;
  assign sda = !(sda_oe || slave_sda_low);

  i2c_master_8bit #(
    .clk_mhz (4),
    .scl_khz (250)
  ) i_i2c_master_8bit (
    .clk    (clk),
    .arst_n (arst_n),
    .addr   (addr),
    .wdata  (wdata),
    .rdata  (rdata),
    .csn    (csn),
    .wrn    (wrn),
    .rdn    (rdn),
    .scl_oe (scl_oe),
    .sda_oe (sda_oe),
    .scl_i  (scl),
    .sda_i  (sda)
  );

  tb_i2c_slave #(
    .slave_addr (dev_addr)
  ) i_slave (
    .scl     (scl),
    .sda     (sda),
    .sda_low (slave_sda_low)
  );

  initial clk = 1'b0;
  always #20 clk = !clk;

  // watchdog
  initial begin
    #(wd_time);
    $display("timeout: the run did not finish in time");
    $display("CHECKS FAILED");
    $fatal(1);
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  task automatic write_byte(input logic [1:0] a, input logic [7:0] d);
    @(posedge clk);
    #2;
    addr  = a;
    wdata = d;
    csn   = 1'b0;
    wrn   = 1'b0;
    @(posedge clk);
    #2;
    csn = 1'b1;
    wrn = 1'b1;
  endtask

  // rdata is registered at the strobe edge
  task automatic read_byte(input logic [1:0] a, output logic [7:0] d);
    @(posedge clk);
    #2;
    addr = a;
    csn  = 1'b0;
    rdn  = 1'b0;
    @(posedge clk);
    #2;
    csn = 1'b1;
    rdn = 1'b1;
    d   = rdata;
  endtask

  task automatic wait_idle(output logic [7:0] flags);
    do begin
      read_byte(2'd3, flags);
    end while (flags[7]);
  endtask

  // control word with byte 0 last since it starts the frame
  task automatic load_ctrl(input logic rd, input logic rs, input logic [6:0] a7,
                           input logic [7:0] sub, input logic [7:0] d);
    write_byte(2'd3, {rd, rs, 6'd0});
    write_byte(2'd2, {1'b0, a7});
    write_byte(2'd1, sub);
    write_byte(2'd0, d);
  endtask

  task automatic run_frame(input logic rd, input logic rs, input logic [6:0] a7,
                           input logic [7:0] sub, input logic [7:0] d,
                           output logic [7:0] flags, output logic [7:0] rd_byte);
    load_ctrl(rd, rs, a7, sub, d);
    wait_idle(flags);
    read_byte(2'd0, rd_byte);
  endtask

  task automatic compare_memory(input string msg);
    for (int i = 0; i < 256; i++) begin
      check({24'd0, i_slave.mem[i]}, {24'd0, mirror[i]}, msg);
    end
  endtask

  initial begin
    logic [31:0] v;
    logic [7:0]  flags;
    logic [7:0]  rb;
    logic [7:0]  sub;
    logic [7:0]  d;
    logic        rs;
    int          reads_before;

    arst_n = 1'b0;
    addr   = 2'd0;
    wdata  = 8'd0;
    csn    = 1'b1;
    wrn    = 1'b1;
    rdn    = 1'b1;
    lfsr   = 32'hb0eed984;

    for (int i = 0; i < 256; i++) begin
      draw(8, v);
      mirror[i]     = v[7:0];
      i_slave.mem[i] = v[7:0];
    end

    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;

    // init and busy until the bus has been free long enough
    read_byte(2'd3, flags);
    check({24'd0, flags}, 32'h84, "status right after reset");
    wait_idle(flags);
    check({24'd0, flags}, 32'h00, "status after init wait");

    // random writes below the read-only range
    for (int n = 0; n < n_writes; n++) begin
      draw(8, v);
      sub = v[7:0];
      if (sub >= 8'hf0) begin
        sub = sub & 8'h7f;
      end
      draw(8, v);
      d = v[7:0];
      run_frame(1'b0, 1'b0, dev_addr, sub, d, flags, rb);
      check({24'd0, flags}, 32'h00, "write status");
      mirror[sub] = d;
    end
    compare_memory("memory after writes");

    // random reads with repeated start or stop then start
    for (int n = 0; n < n_reads; n++) begin
      draw(8, v);
      sub = v[7:0];
      draw(1, v);
      rs           = v[0];
      reads_before = i_slave.read_count;
      run_frame(1'b1, rs, dev_addr, sub, 8'h00, flags, rb);
      check({24'd0, flags}, 32'h10, "read status");
      check({24'd0, rb}, {24'd0, mirror[sub]}, "read data");
      check(i_slave.read_count, reads_before + 1, "slave read count");
      check({31'd0, i_slave.last_restart}, {31'd0, rs}, "repeated start use");
    end

    // wrong slave address
    draw(8, v);
    run_frame(1'b0, 1'b0, 7'h6e, v[7:0], 8'h5a, flags, rb);
    check({24'd0, flags}, 32'h40, "address nack status");
    compare_memory("memory after address nack");

    // read-only subaddress
    draw(4, v);
    sub = {4'hf, v[3:0]};
    run_frame(1'b0, 1'b0, dev_addr, sub, ~mirror[sub], flags, rb);
    check({24'd0, flags}, 32'h20, "data nack status");
    compare_memory("memory after data nack");

    // second go while the first frame runs
    draw(8, v);
    sub = {1'b0, v[6:0]};
    draw(8, v);
    d = v[7:0];
    load_ctrl(1'b0, 1'b0, dev_addr, sub, d);
    write_byte(2'd0, ~d);
    wait_idle(flags);
    check({24'd0, flags}, 32'h08, "overrun status");
    mirror[sub] = d;
    check({24'd0, i_slave.mem[sub]}, {24'd0, d}, "first request kept");
    draw(8, v);
    run_frame(1'b0, 1'b0, dev_addr, sub, v[7:0], flags, rb);
    check({24'd0, flags}, 32'h00, "overrun cleared by next start");
    mirror[sub] = v[7:0];
    compare_memory("memory at end");

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* tb_i2c_slave.sv */
module tb_i2c_slave #(
  parameter logic [6:0] slave_addr = 7'h6f
) (
  input  logic scl,
  input  logic sda,
  output logic sda_low
);

  typedef enum logic [2:0] {
    s_idle, s_rx, s_ack, s_tx, s_mack
  } slave_state_e;

  // register memory, preloaded by the testbench
  logic [7:0]   mem [256];
  // read log: count and how the last read frame was entered
  int           read_count;
  logic         last_restart;

  slave_state_e state;
  logic [3:0]   cnt;
  int           byte_idx;
  logic [7:0]   sh;
  logic [7:0]   sub;
  logic [7:0]   tx_data;
  logic         rd_mode;
  logic         in_frame;
  logic         frame_restart;
  logic         prev_scl;
  logic         prev_sda;

  initial begin
    sda_low       = 1'b0;
    state         = s_idle;
    cnt           = 4'd0;
    byte_idx      = 0;
    read_count    = 0;
    last_restart  = 1'b0;
    in_frame      = 1'b0;
    frame_restart = 1'b0;
    rd_mode       = 1'b0;
    prev_scl      = 1'b1;
    prev_sda      = 1'b1;
  end

  // sample on scl high edge
  task scl_rise();
    if ((state == s_rx) && (cnt < 4'd8)) begin
      sh  = {sh[6:0], sda};
      cnt = cnt + 4'd1;
    end
  endtask

  // drive sda only while scl is low
  task scl_fall();
    case (state)
      s_rx: begin
        if (cnt == 4'd8) begin
          state = s_idle;
          if (byte_idx == 0) begin
            if (sh[7:1] == slave_addr) begin
              rd_mode = sh[0];
              if (rd_mode) begin
                read_count   = read_count + 1;
                last_restart = frame_restart;
              end
              state = s_ack;
            end
          end else if (byte_idx == 1) begin
            sub   = sh;
            state = s_ack;
          end else if (sub < 8'hf0) begin
            // upper registers are read only, nack
            mem[sub] = sh;
            state    = s_ack;
          end
          sda_low = (state == s_ack);
        end
      end
      s_ack: begin
        sda_low = 1'b0;
        if (rd_mode) begin
          // first read bit goes out right after the ack
          tx_data = mem[sub];
          sda_low = !tx_data[7];
          cnt     = 4'd1;
          state   = s_tx;
        end else begin
          cnt      = 4'd0;
          byte_idx = byte_idx + 1;
          state    = s_rx;
        end
      end
      s_tx: begin
        if (cnt == 4'd8) begin
          sda_low = 1'b0;
          state   = s_mack;
        end else begin
          sda_low = !tx_data[3'd7 - cnt[2:0]];
          cnt     = cnt + 4'd1;
        end
      end
      s_mack: state = s_idle;
      default: sda_low = 1'b0;
    endcase
  endtask

  // scl and sda never change in the same step
  always @(scl or sda) begin
    if (scl !== prev_scl) begin
      prev_scl = scl;
      prev_sda = sda;
      if (scl === 1'b1) begin
        scl_rise();
      end else begin
        scl_fall();
      end
    end else if (sda !== prev_sda) begin
      prev_sda = sda;
      if (scl === 1'b1) begin
        if (sda === 1'b0) begin
          // start, or repeated start inside a frame
          frame_restart = in_frame;
          in_frame      = 1'b1;
          state         = s_rx;
          cnt           = 4'd0;
          byte_idx      = 0;
          sda_low       = 1'b0;
        end else begin
          // stop
          in_frame = 1'b0;
          state    = s_idle;
          sda_low  = 1'b0;
        end
      end
    end
  end

endmodule
